/* Bender.yml */
package:
  name: pipe_core

sources:
  - rvPkg.sv
  - regFile.sv
  - decoder.sv
  - hazardUnit.sv
  - execUnit.sv
  - dataMem.sv
  - pipeCore.sv
  - target: test
    files:
      - hazard_properties.sv
      - coreChecker.sv
      - coreTb.sv

/* all.f */
rvPkg.sv
regFile.sv
decoder.sv
hazardUnit.sv
execUnit.sv
dataMem.sv
pipeCore.sv
hazard_properties.sv
coreChecker.sv
coreTb.sv

/* coreChecker.sv */
`timescale 1ns/1ps
`default_nettype none

module coreChecker #(
    parameter int SLOTS = 8
) (
    input  logic                      clk,
    input  logic                      arstN,
    input  rvPkg::wordT               imemAddr,
    input  logic                      retireValid,
    input  rvPkg::regIdxT             retireRd,
    input  rvPkg::wordT               retireData,
    input  rvPkg::regIdxT [SLOTS-1:0] expRdList,
    input  rvPkg::wordT   [SLOTS-1:0] expValList,
    input  int                        expCount,
    output int                        seenCount,
    output int                        errorCount
);

    // Set during reset so that the first fetch after it can be checked
    logic firstFetch;

    // Retirements are checked strictly in program order
    // Counts restart with every reset so each test stands alone
    always @(posedge clk or negedge arstN) begin : compareRetire
        int newErrors;
        if (!arstN) begin
            seenCount  <= 0;
            errorCount <= 0;
            firstFetch <= 1'b1;
        end else begin
            newErrors = 0;
            // The PC leaves reset at zero and only ever holds word addresses
            if (firstFetch && (imemAddr !== 32'd0)) begin
                $display("MISMATCH time %0t imemAddr expected %h actual %h",
                         $time, 32'd0, imemAddr);
                newErrors++;
            end
            if (imemAddr[1:0] !== 2'b00) begin
                $display("MISMATCH time %0t imemAddr[1:0] expected 0 actual %0d",
                         $time, imemAddr[1:0]);
                newErrors++;
            end
            firstFetch <= 1'b0;
            if (retireValid) begin
                if (seenCount >= expCount) begin
                    $display("Unexpected retirement at %0t: x%0d written with %h beyond %0d",
                             $time, retireRd, retireData, expCount);
                    newErrors++;
                end else begin
                    if (retireRd !== expRdList[seenCount]) begin
                        $display("MISMATCH time %0t retireRd expected %0d actual %0d",
                                 $time, expRdList[seenCount], retireRd);
                        newErrors++;
                    end
                    if (retireData !== expValList[seenCount]) begin
                        $display("MISMATCH time %0t retireData expected %h actual %h",
                                 $time, expValList[seenCount], retireData);
                        newErrors++;
                    end
                    seenCount <= seenCount + 1;
                end
            end
            errorCount <= errorCount + newErrors;
        end
    end

endmodule

`default_nettype wire

/* coreTb.sv */
`timescale 1ns/1ps
`default_nettype none

module coreTb;
    import rvPkg::*;

    localparam int NUM_TESTS = 5;
    // Program rows and expected retirements per test
    localparam int SLOTS = 8;
    localparam int RETIRE_TIMEOUT = 200;
    // Long enough for anything still in the pipe to reach writeback
    localparam int DRAIN_CYCLES = 8;

    logic   clk = 1'b0;
    logic   arstN = 1'b0;
    wordT   imemAddr;
    wordT   imemData;
    logic   retireValid;
    regIdxT retireRd;
    wordT   retireData;

    // Instruction memory model, reloaded at the start of every test
    wordT imem [SLOTS];

    // Expected retirements handed to the checker
    regIdxT [SLOTS-1:0] expRdList;
    wordT   [SLOTS-1:0] expValList;
    int                 expCount;
    int                 seenCount;
    int                 errorCount;

    // Program table, one row per test
    string  testNames [NUM_TESTS];
    wordT   progTable [NUM_TESTS][SLOTS];
    int     progLen [NUM_TESTS];
    regIdxT rdTable [NUM_TESTS][SLOTS];
    wordT   valTable [NUM_TESTS][SLOTS];
    int     retireLen [NUM_TESTS];

    int passedTests;
    int failedTests;

    always #10 clk = ~clk;

    // Fetch is answered in the same cycle; past the program the core sees NOPs
    always_comb begin
        if (imemAddr[31:5] == '0) begin
            imemData = imem[imemAddr[4:2]];
        end else begin
            imemData = NOP_WORD;
        end
    end

    pipeCore dut_i (
        .clk         (clk),
        .arstN       (arstN),
        .imemAddr    (imemAddr),
        .imemData    (imemData),
        .retireValid (retireValid),
        .retireRd    (retireRd),
        .retireData  (retireData)
    );

    coreChecker #(.SLOTS(SLOTS)) coreChecker_i (
        .clk         (clk),
        .arstN       (arstN),
        .imemAddr    (imemAddr),
        .retireValid (retireValid),
        .retireRd    (retireRd),
        .retireData  (retireData),
        .expRdList   (expRdList),
        .expValList  (expValList),
        .expCount    (expCount),
        .seenCount   (seenCount),
        .errorCount  (errorCount)
    );

    // Builds an R-type word and sets funct7 bit 5 for SUB
    function automatic wordT rTypeWord(input logic sub, input logic [2:0] f3,
                                       input regIdxT rd, input regIdxT rs1,
                                       input regIdxT rs2);
        return {1'b0, sub, 5'b0, rs2, rs1, f3, rd, OP_R};
    endfunction

    // Builds an I-type word for ADDI and LW
    function automatic wordT iTypeWord(input logic [6:0] op, input logic [2:0] f3,
                                       input regIdxT rd, input regIdxT rs1, input int imm);
        return {imm[11:0], rs1, f3, rd, op};
    endfunction

    function automatic wordT storeWord(input regIdxT rs2, input regIdxT rs1, input int imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OP_STORE};
    endfunction

    // Offset is in bytes relative to the branch itself
    function automatic wordT branchWord(input logic [2:0] f3, input regIdxT rs1,
                                        input regIdxT rs2, input int imm);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OP_BRANCH};
    endfunction

    function automatic wordT jalWord(input regIdxT rd, input int imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OP_JAL};
    endfunction

    task appendInstr(input int t, input wordT w);
        progTable[t][progLen[t]] = w;
        progLen[t]++;
    endtask

    task appendRetire(input int t, input regIdxT rd, input wordT val);
        rdTable[t][retireLen[t]]  = rd;
        valTable[t][retireLen[t]] = val;
        retireLen[t]++;
    endtask

    // Expected values are worked out from ISA semantics in program order
    task buildTable;
        for (int t = 0; t < NUM_TESTS; t++) begin
            progLen[t]   = 0;
            retireLen[t] = 0;
            for (int i = 0; i < SLOTS; i++) begin
                progTable[t][i] = NOP_WORD;
                rdTable[t][i]   = '0;
                valTable[t][i]  = '0;
            end
        end

        // Each result feeds the next, so operands come from memory and writeback
        testNames[0] = "alu forwarding";
        appendInstr(0, iTypeWord(OP_I, 3'b000, 1, 0, 5));
        appendInstr(0, rTypeWord(1'b0, 3'b000, 2, 1, 1));
        appendInstr(0, rTypeWord(1'b1, 3'b000, 3, 2, 1));
        appendInstr(0, rTypeWord(1'b0, 3'b111, 4, 3, 2));
        appendInstr(0, rTypeWord(1'b0, 3'b110, 5, 3, 2));
        appendInstr(0, iTypeWord(OP_I, 3'b000, 6, 0, -3));
        appendInstr(0, rTypeWord(1'b1, 3'b000, 7, 5, 6));
        appendRetire(0, 1, 32'd5);
        appendRetire(0, 2, 32'd10);
        appendRetire(0, 3, 32'd5);
        appendRetire(0, 4, 32'd0);
        appendRetire(0, 5, 32'd15);
        appendRetire(0, 6, 32'hFFFF_FFFD);
        appendRetire(0, 7, 32'd18);

        // Store then load of the same word, each load used right away
        testNames[1] = "load use and store load";
        appendInstr(1, iTypeWord(OP_I, 3'b000, 1, 0, 42));
        appendInstr(1, storeWord(1, 0, 8));
        appendInstr(1, iTypeWord(OP_LOAD, 3'b010, 2, 0, 8));
        appendInstr(1, rTypeWord(1'b0, 3'b000, 3, 2, 2));
        appendInstr(1, iTypeWord(OP_I, 3'b000, 4, 0, 7));
        appendInstr(1, storeWord(4, 0, 12));
        appendInstr(1, iTypeWord(OP_LOAD, 3'b010, 5, 0, 12));
        appendInstr(1, rTypeWord(1'b1, 3'b000, 6, 5, 1));
        appendRetire(1, 1, 32'd42);
        appendRetire(1, 2, 32'd42);
        appendRetire(1, 3, 32'd84);
        appendRetire(1, 4, 32'd7);
        appendRetire(1, 5, 32'd7);
        appendRetire(1, 6, 32'hFFFF_FFDD);

        // BEQ at 8 jumps to 20 over x3 and x4, BNE at 20 falls through
        testNames[2] = "branch taken and not taken";
        appendInstr(2, iTypeWord(OP_I, 3'b000, 1, 0, 3));
        appendInstr(2, iTypeWord(OP_I, 3'b000, 2, 0, 3));
        appendInstr(2, branchWord(3'b000, 1, 2, 12));
        appendInstr(2, iTypeWord(OP_I, 3'b000, 3, 0, 99));
        appendInstr(2, iTypeWord(OP_I, 3'b000, 4, 0, 98));
        appendInstr(2, branchWord(3'b001, 1, 2, 8));
        appendInstr(2, iTypeWord(OP_I, 3'b000, 5, 0, 11));
        appendInstr(2, iTypeWord(OP_I, 3'b000, 6, 5, 1));
        appendRetire(2, 1, 32'd3);
        appendRetire(2, 2, 32'd3);
        appendRetire(2, 5, 32'd11);
        appendRetire(2, 6, 32'd12);

        // JAL at 4 links 8 into x7 and lands on 16
        testNames[3] = "jal link and skip";
        appendInstr(3, iTypeWord(OP_I, 3'b000, 1, 0, 1));
        appendInstr(3, jalWord(7, 12));
        appendInstr(3, iTypeWord(OP_I, 3'b000, 2, 0, 50));
        appendInstr(3, iTypeWord(OP_I, 3'b000, 3, 0, 51));
        appendInstr(3, rTypeWord(1'b0, 3'b000, 4, 7, 1));
        appendInstr(3, iTypeWord(OP_I, 3'b000, 5, 0, -1));
        appendRetire(3, 1, 32'd1);
        appendRetire(3, 7, 32'd8);
        appendRetire(3, 4, 32'd9);
        appendRetire(3, 5, 32'hFFFF_FFFF);

        // Writes to x0 from ADDI, OR and LW must all vanish
        testNames[4] = "x0 writes";
        appendInstr(4, iTypeWord(OP_I, 3'b000, 0, 0, 77));
        appendInstr(4, rTypeWord(1'b0, 3'b000, 1, 0, 0));
        appendInstr(4, iTypeWord(OP_I, 3'b000, 2, 0, 5));
        appendInstr(4, rTypeWord(1'b0, 3'b110, 0, 2, 2));
        appendInstr(4, rTypeWord(1'b0, 3'b000, 3, 0, 2));
        appendInstr(4, iTypeWord(OP_LOAD, 3'b010, 0, 0, 0));
        appendInstr(4, iTypeWord(OP_I, 3'b000, 4, 0, 6));
        appendRetire(4, 1, 32'd0);
        appendRetire(4, 2, 32'd5);
        appendRetire(4, 3, 32'd5);
        appendRetire(4, 4, 32'd6);
    endtask

    task runTest(input int t);
        int waitCycles;
        int drain;
        int testErrors;
        bit timedOut;
        @(posedge clk);
        arstN <= 1'b0;
        for (int i = 0; i < SLOTS; i++) begin
            imem[i]       <= progTable[t][i];
            expRdList[i]  <= rdTable[t][i];
            expValList[i] <= valTable[t][i];
        end
        expCount <= retireLen[t];
        repeat (4) @(posedge clk);
        arstN <= 1'b1;

        // Wait for the checker to count every expected retirement
        waitCycles = 0;
        @(negedge clk);
        while ((seenCount < expCount) && (waitCycles < RETIRE_TIMEOUT)) begin
            @(negedge clk);
            waitCycles++;
        end
        timedOut = (seenCount < expCount);

        // Anything retiring after the last expected result is an error
        drain = 0;
        while (drain < DRAIN_CYCLES) begin
            @(negedge clk);
            drain++;
        end

        testErrors = errorCount;
        if (timedOut) begin
            $display("Test %s timed out after %0d cycles with %0d of %0d retirements seen",
                     testNames[t], RETIRE_TIMEOUT, seenCount, expCount);
            testErrors++;
        end
        if (testErrors == 0) begin
            passedTests++;
            $display("PASS  %s", testNames[t]);
        end else begin
            failedTests++;
            $display("FAIL  %s with %0d errors", testNames[t], testErrors);
        end
    endtask

    initial begin
        passedTests = 0;
        failedTests = 0;
        expRdList   = '0;
        expValList  = '0;
        expCount    = 0;
        for (int i = 0; i < SLOTS; i++) begin
            imem[i] = NOP_WORD;
        end
        buildTable();
        for (int t = 0; t < NUM_TESTS; t++) begin
            runTest(t);
        end
        $display("Tests run %0d, passed %0d, failed %0d, assertion failures %0d",
                 NUM_TESTS, passedTests, failedTests, dut_i.hazardProps_i.assertFails);
        if ((failedTests == 0) && (dut_i.hazardProps_i.assertFails == 0)) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* dataMem.sv */
`timescale 1ns/1ps
`default_nettype none

module dataMem (
    input  logic        clk,
    input  logic        arstN,
    input  rvPkg::wordT addr,
    input  logic        writeEn,
    input  rvPkg::wordT writeData,
    output rvPkg::wordT readData
);
    import rvPkg::*;

    wordT                     mem [DMEM_WORDS];
    logic [DMEM_IDX_BITS-1:0] wordIdx;

    // Byte offset bits are dropped and upper bits ignored, so
    // addresses wrap around the memory size
    assign wordIdx = addr[2 +: DMEM_IDX_BITS];

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < DMEM_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else if (writeEn) begin
            mem[wordIdx] <= writeData;
        end
    end

    // Read is combinational so a load has its data within the memory stage
    assign readData = mem[wordIdx];

endmodule

`default_nettype wire

/* decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module decoder (
    input  rvPkg::wordT   instr,
    output rvPkg::regIdxT rs1,
    output rvPkg::regIdxT rs2,
    output rvPkg::regIdxT rd,
    output rvPkg::wordT   imm,
    output rvPkg::aluOpT  aluOp,
    output logic          useImm,
    output logic          regWrite,
    output logic          memRead,
    output logic          memWrite,
    output logic          branch,
    output logic          branchNe,
    output logic          jump
);
    import rvPkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       funct7b5;

    assign opcode   = instr[6:0];
    assign funct3   = instr[14:12];
    assign funct7b5 = instr[30];

    always_comb begin
        // Start from a bubble and switch on only what the opcode needs
        rs1      = '0;
        rs2      = '0;
        rd       = '0;
        imm      = '0;
        aluOp    = ALU_ADD;
        useImm   = 1'b0;
        regWrite = 1'b0;
        memRead  = 1'b0;
        memWrite = 1'b0;
        branch   = 1'b0;
        branchNe = 1'b0;
        jump     = 1'b0;

        // Unused source fields stay at zero so they cannot cause false stalls
        case (opcode)
            OP_R: begin
                rs1      = instr[19:15];
                rs2      = instr[24:20];
                rd       = instr[11:7];
                regWrite = 1'b1;
                if (funct3 == 3'b111) begin
                    aluOp = ALU_AND;
                end else if (funct3 == 3'b110) begin
                    aluOp = ALU_OR;
                end else if (funct7b5) begin
                    aluOp = ALU_SUB;
                end
            end
            OP_I, OP_LOAD: begin
                // ADDI and LW both add a sign-extended I immediate
                rs1      = instr[19:15];
                rd       = instr[11:7];
                imm      = {{20{instr[31]}}, instr[31:20]};
                useImm   = 1'b1;
                regWrite = 1'b1;
                memRead  = (opcode == OP_LOAD);
            end
            OP_STORE: begin
                rs1      = instr[19:15];
                rs2      = instr[24:20];
                imm      = {{20{instr[31]}}, instr[31:25], instr[11:7]};
                useImm   = 1'b1;
                memWrite = 1'b1;
            end
            OP_BRANCH: begin
                // funct3 bit 0 tells BNE from BEQ
                rs1      = instr[19:15];
                rs2      = instr[24:20];
                imm      = {{19{instr[31]}}, instr[31], instr[7],
                            instr[30:25], instr[11:8], 1'b0};
                aluOp    = ALU_SUB;
                branch   = 1'b1;
                branchNe = funct3[0];
            end
            OP_JAL: begin
                rd       = instr[11:7];
                imm      = {{11{instr[31]}}, instr[31], instr[19:12],
                            instr[20], instr[30:21], 1'b0};
                regWrite = 1'b1;
                jump     = 1'b1;
            end
            default: begin
                // Anything else travels down the pipe as a bubble
            end
        endcase
    end

endmodule

`default_nettype wire

/* execUnit.sv */
`timescale 1ns/1ps
`default_nettype none

module execUnit (
    input  rvPkg::wordT   pcE,
    input  rvPkg::wordT   rs1Data,
    input  rvPkg::wordT   rs2Data,
    input  rvPkg::wordT   imm,
    input  rvPkg::aluOpT  aluOp,
    input  logic          useImm,
    input  logic          branch,
    input  logic          branchNe,
    input  rvPkg::fwdSelT forwardA,
    input  rvPkg::fwdSelT forwardB,
    input  rvPkg::wordT   aluResultM,
    input  rvPkg::wordT   loadDataM,
    input  rvPkg::wordT   resultW,
    output rvPkg::wordT   aluResult,
    output rvPkg::wordT   storeData,
    output logic          branchTaken,
    output rvPkg::wordT   target
);
    import rvPkg::*;

    wordT srcA;
    wordT srcB;
    wordT aluB;

    // Replaces a stale register value with the newer one in flight
    function automatic wordT pickOperand(input fwdSelT sel, input wordT regVal);
        wordT val;
        case (sel)
            FWD_WB:     val = resultW;
            FWD_ALU_M:  val = aluResultM;
            FWD_LOAD_M: val = loadDataM;
            default:    val = regVal;
        endcase
        return val;
    endfunction

    assign srcA = pickOperand(forwardA, rs1Data);
    assign srcB = pickOperand(forwardB, rs2Data);

    // Stores send the forwarded rs2 to memory, not the immediate
    assign storeData = srcB;
    assign aluB      = useImm ? imm : srcB;

    always_comb begin
        case (aluOp)
            ALU_SUB: aluResult = srcA - aluB;
            ALU_AND: aluResult = srcA & aluB;
            ALU_OR:  aluResult = srcA | aluB;
            default: aluResult = srcA + aluB;
        endcase
    end

    // BEQ and BNE compare the forwarded operands directly
    assign branchTaken = branch && (branchNe ? (srcA != srcB) : (srcA == srcB));

    // Branches and JAL share the same PC-relative target
    assign target = pcE + imm;

endmodule

`default_nettype wire

/* hazardUnit.sv */
`timescale 1ns/1ps
`default_nettype none

module hazardUnit (
    input  rvPkg::regIdxT rdE,
    input  rvPkg::regIdxT rdM,
    input  rvPkg::regIdxT rdW,
    input  rvPkg::regIdxT rs1E,
    input  rvPkg::regIdxT rs2E,
    input  rvPkg::regIdxT rs1D,
    input  rvPkg::regIdxT rs2D,
    input  logic          regWriteM,
    input  logic          regWriteW,
    input  logic          memReadE,
    input  logic          memReadM,
    input  logic          branchTaken,
    input  logic          jumpE,
    output rvPkg::fwdSelT forwardA,
    output rvPkg::fwdSelT forwardB,
    output logic          stall,
    output logic          flushExec,
    output logic          flushDecode
);
    import rvPkg::*;

    // Picks the youngest producer of an execute-stage source
    // The memory stage wins over writeback since it holds the newer value
    function automatic fwdSelT pickForward(input regIdxT src);
        fwdSelT sel;
        sel = FWD_NONE;
        // x0 is hard-wired, so nothing is ever forwarded into it
        if (src != '0) begin
            if (memReadM && (src == rdM)) begin
                sel = FWD_LOAD_M;
            end else if (regWriteM && (src == rdM)) begin
                sel = FWD_ALU_M;
            end else if (regWriteW && (src == rdW)) begin
                sel = FWD_WB;
            end
        end
        return sel;
    endfunction

    assign forwardA = pickForward(rs1E);
    assign forwardB = pickForward(rs2E);

    // A consumer right behind a load waits one cycle in decode and then
    // takes the loaded value from writeback
    // A load to x0 also stalls; the bubble costs a cycle and nothing else
    assign stall = memReadE && ((rdE == rs1D) || (rdE == rs2D));

    // A redirect from execute kills the two younger instructions
    assign flushDecode = branchTaken || jumpE;

    // The decode/execute register also takes a bubble while decode is held
    assign flushExec = stall || flushDecode;

endmodule

`default_nettype wire

/* hazard_properties.sv */
`timescale 1ns/1ps
`default_nettype none

module hazardProperties (
    input logic          clk,
    input logic          arstN,
    input rvPkg::regIdxT rdE,
    input rvPkg::fwdSelT forwardA,
    input rvPkg::fwdSelT forwardB,
    input logic          memReadE,
    input logic          stall,
    input logic          flushDecode
);
    import rvPkg::*;

    // Failed assertions are tallied here for the testbench summary
    int assertFails = 0;

    // The load-use stall holds a consumer in decode until its load has
    // reached writeback, so the two never meet in execute and memory
    loadFwdA: assert property (@(posedge clk) disable iff (!arstN)
        forwardA != FWD_LOAD_M)
        else begin
            $error("forwardA took load data from the memory stage");
            assertFails++;
        end

    loadFwdB: assert property (@(posedge clk) disable iff (!arstN)
        forwardB != FWD_LOAD_M)
        else begin
            $error("forwardB took load data from the memory stage");
            assertFails++;
        end

    // The slot behind a redirect is an empty bubble that cannot redirect again
    bubbleAfterRedirect: assert property (@(posedge clk) disable iff (!arstN)
        flushDecode |=> ((rdE == '0) && !flushDecode))
        else begin
            $error("execute holds a live instruction after a redirect");
            assertFails++;
        end

    // The slot behind a stalled load is an empty bubble with no load in it
    bubbleAfterStall: assert property (@(posedge clk) disable iff (!arstN)
        stall |=> ((rdE == '0) && !memReadE))
        else begin
            $error("execute holds a live instruction after a load-use stall");
            assertFails++;
        end

endmodule

// The hazard unit has no clock, so the checks sit in the core next to it
// and watch the very nets that are wired to hazardUnit_i
bind pipeCore hazardProperties hazardProps_i (
    .clk         (clk),
    .arstN       (arstN),
    .rdE         (rdE),
    .forwardA    (forwardA),
    .forwardB    (forwardB),
    .memReadE    (memReadE),
    .stall       (stall),
    .flushDecode (flushDecode)
);

`default_nettype wire

/* pipeCore.sv */
`timescale 1ns/1ps
`default_nettype none

module pipeCore (
    input  logic          clk,
    input  logic          arstN,
    output rvPkg::wordT   imemAddr,
    input  rvPkg::wordT   imemData,
    output logic          retireValid,
    output rvPkg::regIdxT retireRd,
    output rvPkg::wordT   retireData
);
    import rvPkg::*;

    // Fetch stage
    wordT pcF;

    // Decode stage
    wordT   instrD;
    wordT   pcD;
    regIdxT rs1D;
    regIdxT rs2D;
    regIdxT rdD;
    wordT   immD;
    aluOpT  aluOpD;
    logic   useImmD;
    logic   regWriteD;
    logic   memReadD;
    logic   memWriteD;
    logic   branchD;
    logic   branchNeD;
    logic   jumpD;
    wordT   rs1DataD;
    wordT   rs2DataD;

    // Execute stage
    wordT   pcE;
    wordT   rs1DataE;
    wordT   rs2DataE;
    wordT   immE;
    aluOpT  aluOpE;
    logic   useImmE;
    regIdxT rs1E;
    regIdxT rs2E;
    regIdxT rdE;
    logic   regWriteE;
    logic   memReadE;
    logic   memWriteE;
    logic   branchE;
    logic   branchNeE;
    logic   jumpE;
    wordT   aluResultE;
    wordT   storeDataE;
    wordT   targetE;
    wordT   resultE;
    logic   branchTaken;

    // Memory stage
    wordT   aluResultM;
    wordT   storeDataM;
    wordT   loadDataM;
    regIdxT rdM;
    logic   regWriteM;
    logic   memReadM;
    logic   memWriteM;

    // Writeback stage
    wordT   aluResultW;
    wordT   loadDataW;
    regIdxT rdW;
    logic   regWriteW;
    logic   memReadW;
    wordT   resultW;

    // Hazard control
    fwdSelT forwardA;
    fwdSelT forwardB;
    logic   stall;
    logic   flushExec;
    logic   flushDecode;

    assign imemAddr = pcF;

    // flushDecode is exactly a redirect from execute, so it steers the PC
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pcF <= '0;
        end else if (flushDecode) begin
            pcF <= targetE;
        end else if (!stall) begin
            pcF <= pcF + 32'd4;
        end
    end

    // Fetch/decode register, the instruction word decides the controls
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            instrD <= NOP_WORD;
        end else if (flushDecode) begin
            instrD <= NOP_WORD;
        end else if (!stall) begin
            instrD <= imemData;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            pcD <= pcF;
        end
    end

    decoder decoder_i (
        .instr    (instrD),
        .rs1      (rs1D),
        .rs2      (rs2D),
        .rd       (rdD),
        .imm      (immD),
        .aluOp    (aluOpD),
        .useImm   (useImmD),
        .regWrite (regWriteD),
        .memRead  (memReadD),
        .memWrite (memWriteD),
        .branch   (branchD),
        .branchNe (branchNeD),
        .jump     (jumpD)
    );

    regFile regFile_i (
        .clk       (clk),
        .arstN     (arstN),
        .rs1       (rs1D),
        .rs2       (rs2D),
        .rd        (rdW),
        .writeEn   (regWriteW),
        .writeData (resultW),
        .rs1Data   (rs1DataD),
        .rs2Data   (rs2DataD)
    );

    // Decode/execute register; a bubble clears indices along with enables
    // so nothing forwards into or out of an empty slot
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            rs1E      <= '0;
            rs2E      <= '0;
            rdE       <= '0;
            regWriteE <= 1'b0;
            memReadE  <= 1'b0;
            memWriteE <= 1'b0;
            branchE   <= 1'b0;
            branchNeE <= 1'b0;
            jumpE     <= 1'b0;
        end else if (flushExec) begin
            rs1E      <= '0;
            rs2E      <= '0;
            rdE       <= '0;
            regWriteE <= 1'b0;
            memReadE  <= 1'b0;
            memWriteE <= 1'b0;
            branchE   <= 1'b0;
            branchNeE <= 1'b0;
            jumpE     <= 1'b0;
        end else begin
            rs1E      <= rs1D;
            rs2E      <= rs2D;
            rdE       <= rdD;
            regWriteE <= regWriteD;
            memReadE  <= memReadD;
            memWriteE <= memWriteD;
            branchE   <= branchD;
            branchNeE <= branchNeD;
            jumpE     <= jumpD;
        end
    end

    always_ff @(posedge clk) begin
        pcE      <= pcD;
        rs1DataE <= rs1DataD;
        rs2DataE <= rs2DataD;
        immE     <= immD;
        aluOpE   <= aluOpD;
        useImmE  <= useImmD;
    end

    hazardUnit hazardUnit_i (
        .rdE         (rdE),
        .rdM         (rdM),
        .rdW         (rdW),
        .rs1E        (rs1E),
        .rs2E        (rs2E),
        .rs1D        (rs1D),
        .rs2D        (rs2D),
        .regWriteM   (regWriteM),
        .regWriteW   (regWriteW),
        .memReadE    (memReadE),
        .memReadM    (memReadM),
        .branchTaken (branchTaken),
        .jumpE       (jumpE),
        .forwardA    (forwardA),
        .forwardB    (forwardB),
        .stall       (stall),
        .flushExec   (flushExec),
        .flushDecode (flushDecode)
    );

    execUnit execUnit_i (
        .pcE         (pcE),
        .rs1Data     (rs1DataE),
        .rs2Data     (rs2DataE),
        .imm         (immE),
        .aluOp       (aluOpE),
        .useImm      (useImmE),
        .branch      (branchE),
        .branchNe    (branchNeE),
        .forwardA    (forwardA),
        .forwardB    (forwardB),
        .aluResultM  (aluResultM),
        .loadDataM   (loadDataM),
        .resultW     (resultW),
        .aluResult   (aluResultE),
        .storeData   (storeDataE),
        .branchTaken (branchTaken),
        .target      (targetE)
    );

    // JAL's link value replaces the ALU result here so that it forwards
    // from the memory stage like any other ALU write
    assign resultE = jumpE ? (pcE + 32'd4) : aluResultE;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            rdM       <= '0;
            regWriteM <= 1'b0;
            memReadM  <= 1'b0;
            memWriteM <= 1'b0;
        end else begin
            rdM       <= rdE;
            regWriteM <= regWriteE;
            memReadM  <= memReadE;
            memWriteM <= memWriteE;
        end
    end

    always_ff @(posedge clk) begin
        aluResultM <= resultE;
        storeDataM <= storeDataE;
    end

    dataMem dataMem_i (
        .clk       (clk),
        .arstN     (arstN),
        .addr      (aluResultM),
        .writeEn   (memWriteM),
        .writeData (storeDataM),
        .readData  (loadDataM)
    );

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            rdW       <= '0;
            regWriteW <= 1'b0;
            memReadW  <= 1'b0;
        end else begin
            rdW       <= rdM;
            regWriteW <= regWriteM;
            memReadW  <= memReadM;
        end
    end

    always_ff @(posedge clk) begin
        aluResultW <= aluResultM;
        loadDataW  <= loadDataM;
    end

    // Writeback value: load data, otherwise ALU result or link address
    assign resultW = memReadW ? loadDataW : aluResultW;

    // One strobe per register write; writes to x0 are not retirements
    assign retireValid = regWriteW && (rdW != '0);
    assign retireRd    = rdW;
    assign retireData  = resultW;

endmodule

`default_nettype wire

/* regFile.sv */
`timescale 1ns/1ps
`default_nettype none

module regFile (
    input  logic          clk,
    input  logic          arstN,
    input  rvPkg::regIdxT rs1,
    input  rvPkg::regIdxT rs2,
    input  rvPkg::regIdxT rd,
    input  logic          writeEn,
    input  rvPkg::wordT   writeData,
    output rvPkg::wordT   rs1Data,
    output rvPkg::wordT   rs2Data
);
    import rvPkg::*;

    // x0 has no storage, so the array starts at index one
    wordT regs [1:31];

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEn && (rd != '0)) begin
            regs[rd] <= writeData;
        end
    end

    // A write landing in the same cycle is handed straight to the reader
    // This closes the gap between writeback and decode
    always_comb begin
        if (rs1 == '0) begin
            rs1Data = '0;
        end else if (writeEn && (rd == rs1)) begin
            rs1Data = writeData;
        end else begin
            rs1Data = regs[rs1];
        end
        if (rs2 == '0) begin
            rs2Data = '0;
        end else if (writeEn && (rd == rs2)) begin
            rs2Data = writeData;
        end else begin
            rs2Data = regs[rs2];
        end
    end

endmodule

`default_nettype wire

/* rvPkg.sv */
`default_nettype none

package rvPkg;

    // Data and address word of the core
    typedef logic [31:0] wordT;

    // Index into the 32-entry register file
    typedef logic [4:0] regIdxT;

    // Operand source chosen by the hazard unit for the execute stage
    typedef logic [1:0] fwdSelT;

    // Operation performed by the execute-stage ALU
    typedef logic [2:0] aluOpT;

    // Forwarding selects, in rising order of pipeline proximity
    localparam fwdSelT FWD_NONE   = 2'b00;
    // Result that is being written back this cycle
    localparam fwdSelT FWD_WB     = 2'b01;
    // ALU result sitting in the memory stage
    localparam fwdSelT FWD_ALU_M  = 2'b10;
    // Load data read in the memory stage
    localparam fwdSelT FWD_LOAD_M = 2'b11;

    // ALU operations
    localparam aluOpT ALU_ADD = 3'd0;
    localparam aluOpT ALU_SUB = 3'd1;
    localparam aluOpT ALU_AND = 3'd2;
    localparam aluOpT ALU_OR  = 3'd3;

    // Major opcodes of the supported RV32I subset
    localparam logic [6:0] OP_R      = 7'b0110011;
    localparam logic [6:0] OP_I      = 7'b0010011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_JAL    = 7'b1101111;

    // Data memory depth in words
    localparam int DMEM_WORDS = 64;
    // Number of word-address bits needed to index the data memory
    localparam int DMEM_IDX_BITS = $clog2(DMEM_WORDS);

    // ADDI x0,x0,0, the canonical bubble
    localparam wordT NOP_WORD = 32'h0000_0013;

endpackage

`default_nettype wire
